//--- common/eeprom_cfg.svh
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// CLK cycles per SCL half period, 2 or more
`define EE_SCL_HALF 4

// device type code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// R/W bit, lsb of the control byte
`define EE_CTRL_WR 1'b0
`define EE_CTRL_RD 1'b1

`endif

//--- common/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    // block travels in the control byte, byte_addr as the word address
    typedef struct packed
    {
        logic [2:0] block;
        logic [7:0] byte_addr;
    } eeprom_blk_t;

    typedef union packed
    {
        logic [10:0] index;    // flat array index
        eeprom_blk_t blk;
    } eeprom_addr_u;

    typedef struct packed
    {
        eeprom_op_e   op;
        eeprom_addr_u addr;
        logic [7:0]   wdata;
    } eeprom_req_t;

    typedef struct packed
    {
        eeprom_op_e op;
        logic [7:0] rdata;     // zero for writes
        logic       nack;      // some ack bit came back high
    } eeprom_rsp_t;

    typedef enum logic [1:0]
    {
        BIT_START = 2'd0,
        BIT_STOP  = 2'd1,
        BIT_WRITE = 2'd2,
        BIT_READ  = 2'd3
    } bit_op_e;

    typedef struct packed
    {
        bit_op_e    op;
        logic [7:0] byte_out;
        logic       master_nack;   // read only, high sends NACK after the byte
    } bit_cmd_t;

    typedef struct packed
    {
        logic [7:0] byte_in;
        logic       ack_in;        // write only, low means acknowledged
    } bit_res_t;

endpackage

`default_nettype wire

//--- eeprom_wr/i2c_shifter.sv
`default_nettype none

`include "eeprom_cfg.svh"

module i2c_shifter
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_t cmd,
    output logic                 cmd_ready,
    output logic                 res_valid,
    output eeprom_pkg::bit_res_t res,
    output logic                 scl,
    output logic                 sda_low,
    input  logic                 sda_in
);

    localparam int HALF_LAST = `EE_SCL_HALF - 1;
    localparam int HW = $clog2(`EE_SCL_HALF);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_BUSY = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;

    logic [1:0]          state;
    logic [HW-1:0]       hcnt;       // position inside the half period
    logic [4:0]          phase;      // half periods into the sequence
    eeprom_pkg::bit_op_e op;
    logic [7:0]          shreg;
    logic                mnack;
    logic                ack_r;
    logic                is_byte;
    logic                tick;
    logic                last_phase;
    logic [3:0]          bit_idx;
    logic                data_bit;

    assign cmd_ready = (state == S_IDLE);
    assign res_valid = (state == S_DONE);
    assign res = '{byte_in: shreg, ack_in: ack_r};

    assign is_byte = (op == eeprom_pkg::BIT_WRITE) || (op == eeprom_pkg::BIT_READ);
    assign tick = (hcnt == HW'(HALF_LAST));
    assign bit_idx = phase[4:1];    // 0..7 data, 8 ack
    assign last_phase = is_byte ? (phase == 5'd17) : (phase == 5'd1);

    // pull-low value for the current byte bit
    always_comb
    begin
        if (bit_idx < 4'd8)
            data_bit = (op == eeprom_pkg::BIT_WRITE) ? ~shreg[7] : 1'b0;
        else
            data_bit = (op == eeprom_pkg::BIT_READ) ? ~mnack : 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            hcnt    <= '0;
            phase   <= '0;
            ack_r   <= 1'b0;
            scl     <= 1'b1;    // bus released
            sda_low <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        state <= S_BUSY;
                        hcnt  <= '0;
                        phase <= '0;
                        ack_r <= 1'b0;
                    end
                end
                S_BUSY:
                begin
                    hcnt <= tick ? '0 : hcnt + 1'b1;
                    if (hcnt == '0)
                    begin
                        if (op == eeprom_pkg::BIT_START)
                        begin
                            scl     <= 1'b1;
                            sda_low <= phase[0];    // falls with scl high
                        end
                        else if (op == eeprom_pkg::BIT_STOP)
                        begin
                            scl     <= phase[0];
                            sda_low <= 1'b1;        // low before scl rises
                        end
                        else
                        begin
                            scl <= phase[0];        // low half then high half
                        end
                    end
                    // data moves one cycle after scl has fallen
                    if (is_byte && !phase[0] && hcnt == HW'(1))
                        sda_low <= data_bit;
                    if (tick)
                    begin
                        if (is_byte && phase[0] && bit_idx == 4'd8 &&
                            op == eeprom_pkg::BIT_WRITE)
                            ack_r <= sda_in;
                        if (last_phase)
                        begin
                            state <= S_DONE;
                            if (op == eeprom_pkg::BIT_STOP)
                                sda_low <= 1'b0;    // rises with scl high
                            else
                                scl <= 1'b0;
                        end
                        else
                        begin
                            phase <= phase + 1'b1;
                        end
                    end
                end
                S_DONE:
                begin
                    state <= S_IDLE;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // one register serves both directions, msb first
    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && cmd_valid)
        begin
            op    <= cmd.op;
            shreg <= cmd.byte_out;
            mnack <= cmd.master_nack;
        end
        else if (state == S_BUSY && tick && is_byte && phase[0] && bit_idx < 4'd8)
        begin
            shreg <= {shreg[6:0], sda_in};  // sampled at end of scl high
        end
    end

endmodule

`default_nettype wire

//--- eeprom_wr/eeprom_wr.sv
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_wr
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    input  logic                    rsp_ready,
    output logic                    cmd_valid,
    output eeprom_pkg::bit_cmd_t    cmd,
    input  logic                    cmd_ready,
    input  logic                    res_valid,
    input  eeprom_pkg::bit_res_t    res
);

    // one-hot state bit positions
    localparam int I_IDLE   = 0;
    localparam int I_START1 = 1;
    localparam int I_CTRL_W = 2;
    localparam int I_ADDR   = 3;
    localparam int I_DATA   = 4;
    localparam int I_START2 = 5;
    localparam int I_CTRL_R = 6;
    localparam int I_READ   = 7;
    localparam int I_STOP   = 8;
    localparam int I_RSP    = 9;
    localparam int NS       = 10;

    logic [NS-1:0]           st;
    logic [NS-1:0]           nxt;
    logic                    issued;    // command handed to the shifter
    logic                    nack_q;
    logic [7:0]              rdata_q;
    eeprom_pkg::eeprom_req_t req_q;

    assign req_ready = st[I_IDLE];
    assign rsp_valid = st[I_RSP];
    assign cmd_valid = !st[I_IDLE] && !st[I_RSP] && !issued;
    assign rsp = '{op: req_q.op, rdata: rdata_q, nack: nack_q};

    always_comb
    begin
        nxt = st;
        case (1'b1)
            st[I_IDLE]:
                if (req_valid)
                    nxt = NS'(1) << I_START1;
            st[I_START1]:
                if (res_valid)
                    nxt = NS'(1) << I_CTRL_W;
            st[I_CTRL_W]:
                if (res_valid)
                    nxt = NS'(1) << I_ADDR;
            st[I_ADDR]:
                if (res_valid)
                begin
                    if (req_q.op == eeprom_pkg::OP_WRITE)
                        nxt = NS'(1) << I_DATA;
                    else
                        nxt = NS'(1) << I_START2;   // repeated start
                end
            st[I_DATA]:
                if (res_valid)
                    nxt = NS'(1) << I_STOP;
            st[I_START2]:
                if (res_valid)
                    nxt = NS'(1) << I_CTRL_R;
            st[I_CTRL_R]:
                if (res_valid)
                    nxt = NS'(1) << I_READ;
            st[I_READ]:
                if (res_valid)
                    nxt = NS'(1) << I_STOP;
            st[I_STOP]:
                if (res_valid)
                    nxt = NS'(1) << I_RSP;
            st[I_RSP]:
                if (rsp_ready)
                    nxt = NS'(1) << I_IDLE;
            default:
                nxt = NS'(1) << I_IDLE;
        endcase
    end

    always_comb
    begin
        cmd = '{op: eeprom_pkg::BIT_START, byte_out: 8'h00, master_nack: 1'b0};
        case (1'b1)
            st[I_CTRL_W]:
            begin
                cmd.op       = eeprom_pkg::BIT_WRITE;
                cmd.byte_out = {`EE_DEV_CODE, req_q.addr.blk.block, `EE_CTRL_WR};
            end
            st[I_ADDR]:
            begin
                cmd.op       = eeprom_pkg::BIT_WRITE;
                cmd.byte_out = req_q.addr.blk.byte_addr;
            end
            st[I_DATA]:
            begin
                cmd.op       = eeprom_pkg::BIT_WRITE;
                cmd.byte_out = req_q.wdata;
            end
            st[I_CTRL_R]:
            begin
                cmd.op       = eeprom_pkg::BIT_WRITE;
                cmd.byte_out = {`EE_DEV_CODE, req_q.addr.blk.block, `EE_CTRL_RD};
            end
            st[I_READ]:
            begin
                cmd.op          = eeprom_pkg::BIT_READ;
                cmd.master_nack = 1'b1;    // single byte, end the read
            end
            st[I_STOP]:
                cmd.op = eeprom_pkg::BIT_STOP;
            default:
                cmd.op = eeprom_pkg::BIT_START;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            st     <= NS'(1) << I_IDLE;
            issued <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            st <= nxt;
            if (cmd_valid && cmd_ready)
                issued <= 1'b1;
            else if (res_valid)
                issued <= 1'b0;
            if (req_valid && req_ready)
                nack_q <= 1'b0;
            else if (res_valid)
                nack_q <= nack_q | res.ack_in;  // sticky, no abort
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            req_q   <= req;
            rdata_q <= 8'h00;
        end
        else if (res_valid && st[I_READ])
        begin
            rdata_q <= res.byte_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/eeprom_wr_top.sv
`default_nettype none

module eeprom_wr_top
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    input  logic                    rsp_ready,
    output logic                    scl,
    output logic                    sda_low,
    input  logic                    sda_in
);

    logic                 cmd_valid;
    logic                 cmd_ready;
    eeprom_pkg::bit_cmd_t cmd;
    logic                 res_valid;
    eeprom_pkg::bit_res_t res;

    eeprom_wr i_eeprom_wr
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .res_valid (res_valid),
        .res       (res)
    );

    // open drain, sda_low pulls the line
    i2c_shifter i_i2c_shifter
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .res_valid (res_valid),
        .res       (res),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

endmodule

`default_nettype wire

//--- verif/eeprom_slave_model.sv
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_slave_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_all,
    output logic sda_low
);

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic [7:0]  tx_byte;
    logic [3:0]  bit_cnt;    // scl rises seen in the current byte
    logic [1:0]  byte_no;    // 0 control, 1 word address, 2 data
    logic        selected;
    logic        sending;
    logic        scl_q;
    logic        sda_q;
    logic        start_seen;
    logic        stop_seen;
    logic        scl_rise;
    logic        scl_fall;

    assign start_seen = scl_q && scl && sda_q && !sda;
    assign stop_seen  = scl_q && scl && !sda_q && sda;
    assign scl_rise   = !scl_q && scl;
    assign scl_fall   = scl_q && !scl;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;    // erased part
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            ptr      <= '0;
            bit_cnt  <= '0;
            byte_no  <= '0;
            selected <= 1'b0;
            sending  <= 1'b0;
            sda_low  <= 1'b0;
        end
        else if (start_seen)
        begin
            bit_cnt  <= '0;
            byte_no  <= '0;
            selected <= 1'b1;    // until the control byte says otherwise
            sending  <= 1'b0;
            sda_low  <= 1'b0;
        end
        else if (stop_seen)
        begin
            selected <= 1'b0;
            sending  <= 1'b0;
            sda_low  <= 1'b0;
        end
        else if (scl_rise && selected)
        begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt < 4'd8)
                shreg <= {shreg[6:0], sda};
            else if (sending && sda)
            begin
                sending  <= 1'b0;    // master NACK ends the read
                selected <= 1'b0;
            end
        end
        else if (scl_fall && selected)
        begin
            if (bit_cnt == 4'd8 && sending)
                sda_low <= 1'b0;    // master owns the ack bit
            else if (bit_cnt == 4'd8)
            begin
                if (byte_no == 2'd0)
                begin
                    if (shreg[7:4] == `EE_DEV_CODE && !nack_all)
                    begin
                        sda_low <= 1'b1;
                        if (shreg[0])
                        begin
                            sending <= 1'b1;
                            tx_byte <= mem[ptr];
                        end
                        else
                            ptr[10:8] <= shreg[3:1];    // block bits
                    end
                    else
                        selected <= 1'b0;
                end
                else if (byte_no == 2'd1)
                begin
                    ptr[7:0] <= shreg;
                    sda_low  <= 1'b1;
                end
                else
                begin
                    mem[ptr] <= shreg;
                    sda_low  <= 1'b1;
                end
                if (byte_no != 2'd2)
                    byte_no <= byte_no + 2'd1;
            end
            else if (bit_cnt == 4'd9)
            begin
                bit_cnt <= '0;
                sda_low <= sending ? ~tx_byte[7] : 1'b0;
            end
            else if (sending)
                sda_low <= ~tx_byte[3'd7 - bit_cnt[2:0]];
        end
    end

endmodule

`default_nettype wire

//--- verif/eeprom_wr_sva.sv
`default_nettype none

module eeprom_wr_sva
(
    input logic                    CLK,
    input logic                    RESET,
    input logic                    req_ready,
    input logic                    rsp_valid,
    input eeprom_pkg::eeprom_rsp_t rsp,
    input logic                    rsp_ready,
    input logic                    scl,
    input logic                    sda_low
);

    a_rsp_stable: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp changed while waiting for rsp_ready");

    a_no_req_with_rsp: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending");

    // data moves with scl low, start and stop with scl held high
    a_sda_off_scl_edge: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_low) |-> $stable(scl))
        else $error("sda_low changed on an scl edge");

    a_stop_releases: assert property (@(posedge CLK) disable iff (RESET)
        scl && $fell(sda_low) |=> scl && !sda_low)
        else $error("bus not left released after STOP");

endmodule

bind eeprom_wr_top eeprom_wr_sva i_eeprom_wr_sva
(
    .CLK       (CLK),
    .RESET     (RESET),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready),
    .scl       (scl),
    .sda_low   (sda_low)
);

`default_nettype wire

//--- verif/tb_eeprom_wr.sv
`default_nettype none

`include "eeprom_cfg.svh"

module tb_eeprom_wr;

    localparam int N_ENTRIES = 11;
    localparam int WATCHDOG_CYCLES = N_ENTRIES * 40 * 2 * `EE_SCL_HALF * 2;
    localparam eeprom_pkg::eeprom_op_e WR = eeprom_pkg::OP_WRITE;
    localparam eeprom_pkg::eeprom_op_e RD = eeprom_pkg::OP_READ;

    typedef struct packed
    {
        eeprom_pkg::eeprom_op_e op;
        logic [10:0]            addr;
        logic [7:0]             wdata;
        logic                   nack_all;
        logic [7:0]             exp_rdata;
        logic                   exp_nack;
    } stim_t;

    logic                    CLK;
    logic                    RESET;
    logic                    req_valid;
    eeprom_pkg::eeprom_req_t req;
    logic                    req_ready;
    logic                    rsp_valid;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    rsp_ready;
    logic                    scl;
    logic                    sda_low;
    logic                    slave_sda_low;
    logic                    sda;
    logic                    nack_all;
    stim_t                   stim_tab [N_ENTRIES];
    integer                  seed;

    assign sda = !(sda_low || slave_sda_low);    // pull-up on the wired line

    eeprom_wr_top i_eeprom_wr_top
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda)
    );

    eeprom_slave_model i_eeprom_slave_model
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .sda      (sda),
        .nack_all (nack_all),
        .sda_low  (slave_sda_low)
    );

    always #20 CLK = ~CLK;

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rsp(input eeprom_pkg::eeprom_rsp_t got,
                             input eeprom_pkg::eeprom_rsp_t exp);
        if (got !== exp)
        begin
            $display("mismatch rsp got 0x%h expected 0x%h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bus_idle(input logic got_scl, input logic got_sda_low);
        if (got_scl !== 1'b1 || got_sda_low !== 1'b0)
        begin
            $display("mismatch scl/sda_low got 0x%h/0x%h expected 0x1/0x0",
                     got_scl, got_sda_low);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // op, addr, wdata, nack_all, expected rdata, expected nack
    task automatic fill_table();
        stim_tab[0]  = '{WR, 11'h0A5, 8'h3C, 1'b0, 8'h00, 1'b0};
        stim_tab[1]  = '{RD, 11'h0A5, 8'h00, 1'b0, 8'h3C, 1'b0};
        stim_tab[2]  = '{WR, 11'h7A5, 8'hC3, 1'b0, 8'h00, 1'b0};
        stim_tab[3]  = '{RD, 11'h7A5, 8'h00, 1'b0, 8'hC3, 1'b0};
        stim_tab[4]  = '{RD, 11'h0A5, 8'h00, 1'b0, 8'h3C, 1'b0};    // other block untouched
        stim_tab[5]  = '{RD, 11'h123, 8'h00, 1'b0, 8'hFF, 1'b0};
        stim_tab[6]  = '{WR, 11'h0A5, 8'h55, 1'b1, 8'h00, 1'b1};
        stim_tab[7]  = '{RD, 11'h0A5, 8'h00, 1'b0, 8'h3C, 1'b0};
        stim_tab[8]  = '{RD, 11'h400, 8'h00, 1'b1, 8'hFF, 1'b1};    // nobody drives sda
        stim_tab[9]  = '{WR, 11'h7FF, 8'h81, 1'b0, 8'h00, 1'b0};
        stim_tab[10] = '{RD, 11'h7FF, 8'h00, 1'b0, 8'h81, 1'b0};
    endtask

    task automatic run_entry(input stim_t e);
        eeprom_pkg::eeprom_rsp_t exp;
        int                      hold;
        exp  = '{op: e.op, rdata: e.exp_rdata, nack: e.exp_nack};
        hold = $unsigned($random(seed)) % 8;
        @(posedge CLK);
        #1;
        nack_all        = e.nack_all;
        req.op          = e.op;
        req.addr.index  = e.addr;
        req.wdata       = e.wdata;
        req_valid       = 1'b1;
        @(negedge CLK);
        while (!req_ready)
            @(negedge CLK);
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
        req       = '0;
        @(negedge CLK);
        while (!rsp_valid)
        begin
            check_flag("req_ready", req_ready, 1'b0);
            @(negedge CLK);
        end
        // host stalls, response must hold
        repeat (hold)
        begin
            check_rsp(rsp, exp);
            check_flag("req_ready", req_ready, 1'b0);
            @(negedge CLK);
            check_flag("rsp_valid", rsp_valid, 1'b1);
        end
        check_rsp(rsp, exp);
        check_bus_idle(scl, sda_low);
        @(posedge CLK);
        #1;
        rsp_ready = 1'b1;
        @(posedge CLK);
        #1;
        rsp_ready = 1'b0;
        @(negedge CLK);
        check_flag("rsp_valid", rsp_valid, 1'b0);    // delivered once
        check_flag("req_ready", req_ready, 1'b1);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timed out while waiting for a response from the DUT");
        stop_with_failure();
    end

    initial
    begin
        seed      = 47915;
        CLK       = 1'b0;
        RESET     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        nack_all  = 1'b0;
        fill_table();
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++)
            run_entry(stim_tab[i]);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
common/eeprom_pkg.sv
eeprom_wr/i2c_shifter.sv
eeprom_wr/eeprom_wr.sv
verilog/eeprom_wr_top.sv
verif/eeprom_slave_model.sv
verif/eeprom_wr_sva.sv
verif/tb_eeprom_wr.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_eeprom_wr
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
